// File: ahb_sram_pkg.sv
//////////////////////////////////////////////////////////////////////
// AHB-Lite SRAM slave shared types
// Bus encodings, vector typedefs, memory request structs, lane decode
//////////////////////////////////////////////////////////////////////

package ahb_sram_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Bus fixed at 32 bits, four byte lanes
  localparam int HADDR_W = 32;
  localparam int HDATA_W = 32;
  localparam int HBE_W   = HDATA_W / 8;

  typedef logic [HADDR_W-1:0]   haddr_t;
  typedef logic [HDATA_W-1:0]   hdata_t;
  typedef logic [HBE_W-1:0]     hbe_t;
  // Byte address minus the two lane bits
  typedef logic [HADDR_W-3:0]   word_idx_t;

  //////////////////////////////////////////////////////////////////////
  // AHB encodings
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  // Wider codes are illegal on a 32-bit bus
  typedef enum logic [2:0] {
    HSIZE_BYTE  = 3'b000,
    HSIZE_HWORD = 3'b001,
    HSIZE_WORD  = 3'b010
  } hsize_e;

  typedef enum logic {
    HRESP_OKAY  = 1'b0,
    HRESP_ERROR = 1'b1
  } hresp_e;

  //////////////////////////////////////////////////////////////////////
  // Memory requests
  //////////////////////////////////////////////////////////////////////

  // Write request, valid during the write data phase
  typedef struct packed {
    logic      we;
    hbe_t      be;
    word_idx_t idx;
  } mem_wr_t;

  // Read request, sampled by the array on the accepting edge
  typedef struct packed {
    logic      re;
    word_idx_t idx;
    logic      bypass;
  } mem_rd_t;

  // Lane mask for the size, moved up to the addressed byte
  function automatic hbe_t lane_enables(hsize_e size, logic [1:0] offset);
    hbe_t mask;
    case (size)
      HSIZE_BYTE:  mask = 4'b0001;
      HSIZE_HWORD: mask = 4'b0011;
      default:     mask = 4'b1111;
    endcase
    return mask << offset;
  endfunction

endpackage

// File: ahb_sram_addr_phase.sv
//////////////////////////////////////////////////////////////////////
// AHB-Lite address phase capture for the SRAM slave
// Byte lane decode, read/write collision check, memory requests
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ahb_sram_addr_phase #(
  parameter int MEM_DEPTH = 256
) (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic                  HSEL,
  input  ahb_sram_pkg::haddr_t  HADDR,
  input  logic                  HWRITE,
  input  ahb_sram_pkg::hsize_e  HSIZE,
  input  ahb_sram_pkg::htrans_e HTRANS,
  input  logic                  HREADY,
  output ahb_sram_pkg::mem_wr_t wr_req,
  output ahb_sram_pkg::mem_rd_t rd_req,
  output logic                  stall,
  output logic                  rd_accept
);

  // Word index bits actually decoded by the array
  localparam int MEM_AW = $clog2(MEM_DEPTH);

  logic                    active;
  logic                    wr_we;
  ahb_sram_pkg::hbe_t      wr_be;
  ahb_sram_pkg::word_idx_t phase_idx;
  ahb_sram_pkg::word_idx_t haddr_idx;
  logic                    same_word;
  logic                    full_word;
  logic                    collision;
  logic                    stall_q;

  //////////////////////////////////////////////////////////////////////
  // Address phase decode
  //////////////////////////////////////////////////////////////////////

  assign haddr_idx = HADDR[31:2];

  // IDLE and BUSY carry no transfer
  assign active = HSEL &&
                  (HTRANS == ahb_sram_pkg::HTRANS_NONSEQ ||
                   HTRANS == ahb_sram_pkg::HTRANS_SEQ);

  assign rd_accept = HREADY && active && !HWRITE;

  // Write enable drops whenever the phase is not accepted
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      wr_we <= 1'b0;
    end else begin
      wr_we <= HREADY && active && HWRITE;
    end
  end

  // Lanes and index frozen while HREADY is low
  always_ff @(posedge HCLK) begin
    if (HREADY) begin
      wr_be     <= ahb_sram_pkg::lane_enables(HSIZE, HADDR[1:0]);
      phase_idx <= haddr_idx;
    end
  end

  assign wr_req = '{we: wr_we, be: wr_be, idx: phase_idx};

  //////////////////////////////////////////////////////////////////////
  // Collision with the pending write
  //////////////////////////////////////////////////////////////////////

  // Aliased addresses hit the same physical word
  assign same_word = phase_idx[MEM_AW-1:0] == haddr_idx[MEM_AW-1:0];
  assign full_word = &wr_be;
  assign collision = wr_we && rd_accept && same_word;

  // Partial write lands at the same edge, read must go again
  assign stall = collision && !full_word;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      stall_q <= 1'b0;
    end else begin
      stall_q <= stall;
    end
  end

  // Re-read of the held word during the wait state
  always_comb begin
    if (stall_q) begin
      rd_req = '{re: 1'b1, idx: phase_idx, bypass: 1'b0};
    end else begin
      rd_req = '{re: rd_accept, idx: haddr_idx, bypass: collision && full_word};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bus checks
  //////////////////////////////////////////////////////////////////////

  a_hsize_legal : assert property (@(posedge HCLK) disable iff (!HRESETn)
    (HREADY && active) |-> (HSIZE <= ahb_sram_pkg::HSIZE_WORD));

  a_aligned : assert property (@(posedge HCLK) disable iff (!HRESETn)
    (HREADY && active) |->
      ((HSIZE == ahb_sram_pkg::HSIZE_BYTE) ||
       (HSIZE == ahb_sram_pkg::HSIZE_HWORD && !HADDR[0]) ||
       (HSIZE == ahb_sram_pkg::HSIZE_WORD && HADDR[1:0] == 2'b00)));

endmodule

// File: sram_1r1w.sv
//////////////////////////////////////////////////////////////////////
// Byte-writable 1R1W memory array
// Registered read port with full-word write bypass
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sram_1r1w #(
  parameter int MEM_DEPTH = 256
) (
  input  logic                  HCLK,
  input  ahb_sram_pkg::mem_wr_t wr_req,
  input  ahb_sram_pkg::hdata_t  wdata,
  input  ahb_sram_pkg::mem_rd_t rd_req,
  output ahb_sram_pkg::hdata_t  rdata
);

  localparam int MEM_AW = $clog2(MEM_DEPTH);

  ahb_sram_pkg::hdata_t mem [MEM_DEPTH];

  logic [MEM_AW-1:0] waddr;
  logic [MEM_AW-1:0] raddr;

  //////////////////////////////////////////////////////////////////////
  // Address truncation
  //////////////////////////////////////////////////////////////////////

  // Upper index bits dropped, high words wrap onto low ones
  assign waddr = wr_req.idx[MEM_AW-1:0];
  assign raddr = rd_req.idx[MEM_AW-1:0];

  //////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////

  // One lane per enable bit
  always_ff @(posedge HCLK) begin
    for (int b = 0; b < ahb_sram_pkg::HBE_W; b++) begin
      if (wr_req.we && wr_req.be[b]) begin
        mem[waddr][8*b +: 8] <= wdata[8*b +: 8];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////////////////////////

  // Old word read at the write edge, so full writes come via bypass
  always_ff @(posedge HCLK) begin
    if (rd_req.re) begin
      if (rd_req.bypass) begin
        rdata <= wdata;
      end else begin
        rdata <= mem[raddr];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Bypass needs a full-word write to the same word in this cycle
  a_bypass_full_write : assert property (@(posedge HCLK)
    (rd_req.re && rd_req.bypass) |->
      (wr_req.we && (&wr_req.be) && waddr == raddr));

endmodule

// File: ahb_sram_resp.sv
//////////////////////////////////////////////////////////////////////
// AHB-Lite response side, HREADYOUT and HRDATA
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ahb_sram_resp #(
  parameter bit REGISTERED_OUTPUT = 1'b0
) (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic                  HREADY,
  input  ahb_sram_pkg::htrans_e HTRANS,
  input  logic                  HWRITE,
  input  logic                  stall,
  input  logic                  rd_accept,
  input  ahb_sram_pkg::hdata_t  mem_rdata,
  output ahb_sram_pkg::hdata_t  HRDATA,
  output logic                  HREADYOUT
);

  if (REGISTERED_OUTPUT) begin : g_reg_out
    logic rd_wait;
    logic rd_dphase_q;
    logic stalled_q;

    // SEQ beats wait too, the array has no prefetch
    assign rd_wait = HREADY && !HWRITE &&
                     (HTRANS == ahb_sram_pkg::HTRANS_NONSEQ ||
                      HTRANS == ahb_sram_pkg::HTRANS_SEQ);

    always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
        HREADYOUT   <= 1'b1;
        rd_dphase_q <= 1'b0;
        stalled_q   <= 1'b0;
      end else begin
        // Stalled read gets a second cycle for the re-read word
        HREADYOUT <= !(rd_wait || stall || stalled_q);
        stalled_q <= stall;
        if (HREADY) begin
          rd_dphase_q <= rd_accept;
        end
      end
    end

    // Load at the end of each wait cycle of a read
    always_ff @(posedge HCLK) begin
      if (rd_dphase_q && !HREADYOUT) begin
        HRDATA <= mem_rdata;
      end
    end
  end else begin : g_comb_out
    // One wait state per partial-write collision
    always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
        HREADYOUT <= 1'b1;
      end else begin
        HREADYOUT <= !stall;
      end
    end

    assign HRDATA = mem_rdata;
  end

  // Wait states never chain, except the stalled registered read
  a_single_wait : assert property (@(posedge HCLK) disable iff (!HRESETn)
    (!HREADYOUT && (!REGISTERED_OUTPUT || !$past(HREADYOUT))) |=> HREADYOUT);

endmodule

// File: ahb_sram.sv
//////////////////////////////////////////////////////////////////////
// AHB-Lite single-port SRAM slave, top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ahb_sram #(
  parameter int MEM_DEPTH         = 256,
  parameter bit REGISTERED_OUTPUT = 1'b0
) (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic                  HSEL,
  input  ahb_sram_pkg::haddr_t  HADDR,
  input  ahb_sram_pkg::hdata_t  HWDATA,
  output ahb_sram_pkg::hdata_t  HRDATA,
  input  logic                  HWRITE,
  input  ahb_sram_pkg::hsize_e  HSIZE,
  input  logic [2:0]            HBURST,
  input  logic [3:0]            HPROT,
  input  ahb_sram_pkg::htrans_e HTRANS,
  input  logic                  HMASTLOCK,
  input  logic                  HREADY,
  output logic                  HREADYOUT,
  output ahb_sram_pkg::hresp_e  HRESP
);

  ahb_sram_pkg::mem_wr_t wr_req;
  ahb_sram_pkg::mem_rd_t rd_req;
  ahb_sram_pkg::hdata_t  mem_rdata;
  logic                  stall;
  logic                  rd_accept;

  // HBURST, HPROT and HMASTLOCK carry nothing this slave acts on
  assign HRESP = ahb_sram_pkg::HRESP_OKAY;

  ahb_sram_addr_phase #(
    .MEM_DEPTH (MEM_DEPTH)
  ) u_addr_phase (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (HSEL),
    .HADDR     (HADDR),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HTRANS    (HTRANS),
    .HREADY    (HREADY),
    .wr_req    (wr_req),
    .rd_req    (rd_req),
    .stall     (stall),
    .rd_accept (rd_accept)
  );

  // Write data belongs to the data phase, straight from the bus
  sram_1r1w #(
    .MEM_DEPTH (MEM_DEPTH)
  ) u_sram (
    .HCLK   (HCLK),
    .wr_req (wr_req),
    .wdata  (HWDATA),
    .rd_req (rd_req),
    .rdata  (mem_rdata)
  );

  ahb_sram_resp #(
    .REGISTERED_OUTPUT (REGISTERED_OUTPUT)
  ) u_resp (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HREADY    (HREADY),
    .HTRANS    (HTRANS),
    .HWRITE    (HWRITE),
    .stall     (stall),
    .rd_accept (rd_accept),
    .mem_rdata (mem_rdata),
    .HRDATA    (HRDATA),
    .HREADYOUT (HREADYOUT)
  );

endmodule

// File: tb_clk_gen.sv
//////////////////////////////////////////////////////////////////////
// Testbench clock and power-on reset source
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int CLK_PERIOD   = 8,
  parameter int RESET_CYCLES = 3
) (
  output logic HCLK,
  output logic HRESETn
);

  // Free-running clock, first rising edge half a period in
  initial begin
    HCLK = 1'b0;
    forever #(CLK_PERIOD / 2.0) HCLK = ~HCLK;
  end

  // Reset held over the first few edges, released just after one
  initial begin
    HRESETn = 1'b0;
    repeat (RESET_CYCLES) @(posedge HCLK);
    #1 HRESETn = 1'b1;
  end

endmodule

// File: tb_ahb_sram.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the AHB-Lite SRAM slave
// Pipelined random master, reference memory model, watchdog
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_ahb_sram;

  localparam int MEM_DEPTH  = 64;
  localparam int NUM_TXN    = 2000;
  localparam int CLK_PERIOD = 8;

  // One transfer as seen by the master
  typedef struct packed {
    logic                 valid;
    logic                 write;
    ahb_sram_pkg::haddr_t addr;
    ahb_sram_pkg::hsize_e size;
  } xfer_t;

  logic                  HCLK;
  logic                  HRESETn;
  logic                  HSEL;
  ahb_sram_pkg::haddr_t  HADDR;
  ahb_sram_pkg::hdata_t  HWDATA;
  ahb_sram_pkg::hdata_t  HRDATA;
  logic                  HWRITE;
  ahb_sram_pkg::hsize_e  HSIZE;
  logic [2:0]            HBURST;
  logic [3:0]            HPROT;
  ahb_sram_pkg::htrans_e HTRANS;
  logic                  HMASTLOCK;
  logic                  HREADYOUT;
  ahb_sram_pkg::hresp_e  HRESP;

  // Reference memory, bytes marked valid once written
  ahb_sram_pkg::hdata_t model_mem [MEM_DEPTH];
  ahb_sram_pkg::hbe_t   model_valid [MEM_DEPTH];

  logic [31:0]          lfsr;
  logic [7:0]           last_idx;
  xfer_t                ap;
  xfer_t                dp;
  ahb_sram_pkg::hdata_t dp_wdata;
  int                   dp_waits;
  int                   dp_exp_waits;
  int                   issued;
  int                   reads;
  int                   waited;

  tb_clk_gen #(.CLK_PERIOD(CLK_PERIOD), .RESET_CYCLES(3)) u_clk_gen (
    .HCLK    (HCLK),
    .HRESETn (HRESETn)
  );

  // Single-slave bus, HREADY is the slave's own HREADYOUT
  ahb_sram #(.MEM_DEPTH(MEM_DEPTH), .REGISTERED_OUTPUT(1'b0)) u_dut (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (HSEL),
    .HADDR     (HADDR),
    .HWDATA    (HWDATA),
    .HRDATA    (HRDATA),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HBURST    (HBURST),
    .HPROT     (HPROT),
    .HTRANS    (HTRANS),
    .HMASTLOCK (HMASTLOCK),
    .HREADY    (HREADYOUT),
    .HREADYOUT (HREADYOUT),
    .HRESP     (HRESP)
  );

  //////////////////////////////////////////////////////////////////////
  // Random source and reference rules
  //////////////////////////////////////////////////////////////////////

  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Lanes from the offset up to offset plus transfer bytes
  function automatic ahb_sram_pkg::hbe_t lanes_of(ahb_sram_pkg::hsize_e size, int off);
    ahb_sram_pkg::hbe_t be;
    int nbytes;
    nbytes = 1 << size;
    for (int b = 0; b < 4; b++) begin
      be[b] = (b >= off) && (b < off + nbytes);
    end
    return be;
  endfunction

  function automatic ahb_sram_pkg::hdata_t byte_mask(ahb_sram_pkg::hbe_t be);
    ahb_sram_pkg::hdata_t m;
    for (int b = 0; b < 4; b++) begin
      m[8*b +: 8] = {8{be[b]}};
    end
    return m;
  endfunction

  // Physical word, high addresses alias modulo the depth
  function automatic int word_of(ahb_sram_pkg::haddr_t addr);
    return int'(addr[31:2]) % MEM_DEPTH;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_rdata(ahb_sram_pkg::haddr_t addr, ahb_sram_pkg::hdata_t got,
                             ahb_sram_pkg::hdata_t exp, ahb_sram_pkg::hdata_t mask);
    if ((got & mask) !== (exp & mask)) begin
      report_failure($sformatf("FAIL %0t: read of %h gave %h, expected %h on bytes %h",
                               $time, addr, got, exp, mask));
    end
  endtask

  task automatic check_waits(ahb_sram_pkg::haddr_t addr, int got, int exp);
    if (got != exp) begin
      report_failure($sformatf("FAIL %0t: read of %h took %0d wait states, expected %0d",
                               $time, addr, got, exp));
    end
  endtask

  task automatic check_resp(ahb_sram_pkg::hresp_e got);
    if (got !== ahb_sram_pkg::HRESP_OKAY) begin
      report_failure($sformatf("FAIL %0t: HRESP is %0d, expected OKAY", $time, got));
    end
  endtask

  task automatic check_ready(logic got, string what);
    if (got !== 1'b1) begin
      report_failure($sformatf("FAIL %0t: HREADYOUT low %s", $time, what));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Master driver
  //////////////////////////////////////////////////////////////////////

  task automatic drive_idle();
    ap     = '0;
    HSEL   = 1'b0;
    HTRANS = ahb_sram_pkg::HTRANS_IDLE;
    HWRITE = 1'b0;
    HADDR  = '0;
    HSIZE  = ahb_sram_pkg::HSIZE_WORD;
  endtask

  // Kinds 0-2 write, 3-5 read, 6 IDLE or BUSY, 7 deselected write
  task automatic pick_transfer();
    logic [2:0]           kind;
    logic [7:0]           idx;
    logic [1:0]           off;
    ahb_sram_pkg::hsize_e size;
    kind = 3'(take_bits(3));
    case (2'(take_bits(2)))
      2'd0:    size = ahb_sram_pkg::HSIZE_BYTE;
      2'd1:    size = ahb_sram_pkg::HSIZE_HWORD;
      default: size = ahb_sram_pkg::HSIZE_WORD;
    endcase
    // Natural alignment for the size
    case (size)
      ahb_sram_pkg::HSIZE_BYTE:  off = 2'(take_bits(2));
      ahb_sram_pkg::HSIZE_HWORD: off = {1'(take_bits(1)), 1'b0};
      default:                   off = 2'b00;
    endcase
    // Half the time hit the previous word, maybe through an alias
    if (take_bits(1) == 32'd1) begin
      idx = {2'(take_bits(2)), last_idx[5:0]};
    end else begin
      idx = 8'(take_bits(8));
    end
    last_idx = idx;
    ap.valid = kind < 3'd6;
    ap.write = (kind < 3'd3) || (kind >= 3'd6);
    ap.size  = size;
    ap.addr  = {4'(take_bits(4)), 18'b0, idx, off};
    HSEL     = kind != 3'd7;
    HWRITE   = ap.write;
    HSIZE    = size;
    HADDR    = ap.addr;
    if (kind == 3'd6) begin
      HTRANS = take_bits(1) == 32'd1 ? ahb_sram_pkg::HTRANS_BUSY : ahb_sram_pkg::HTRANS_IDLE;
    end else if (kind == 3'd7 || take_bits(1) == 32'd0) begin
      HTRANS = ahb_sram_pkg::HTRANS_NONSEQ;
    end else begin
      HTRANS = ahb_sram_pkg::HTRANS_SEQ;
    end
    issued++;
  endtask

  // End of a data phase, write into the model or check the read
  task automatic complete_data_phase(ahb_sram_pkg::hdata_t rdata, ahb_sram_pkg::hresp_e resp);
    int                 w;
    ahb_sram_pkg::hbe_t be;
    w  = word_of(dp.addr);
    be = lanes_of(dp.size, int'(dp.addr[1:0]));
    check_resp(resp);
    if (dp.write) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          model_mem[w][8*b +: 8] = dp_wdata[8*b +: 8];
        end
      end
      model_valid[w] = model_valid[w] | be;
    end else begin
      check_rdata(dp.addr, rdata, model_mem[w], byte_mask(model_valid[w]));
      check_waits(dp.addr, dp_waits, dp_exp_waits);
      reads++;
      waited += dp_waits;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic                 ready;
    ahb_sram_pkg::hdata_t rdata;
    ahb_sram_pkg::hresp_e resp;
    lfsr      = 32'h3922_68c2;
    last_idx  = '0;
    issued    = 0;
    reads     = 0;
    waited    = 0;
    dp        = '0;
    dp_wdata  = '0;
    dp_waits  = 0;
    HWDATA    = '0;
    HBURST    = 3'b000;
    HPROT     = 4'b0011;
    HMASTLOCK = 1'b0;
    drive_idle();
    for (int i = 0; i < MEM_DEPTH; i++) begin
      model_mem[i]   = '0;
      model_valid[i] = '0;
    end
    @(posedge HRESETn);
    @(negedge HCLK);
    check_ready(HREADYOUT, "after reset");
    check_resp(HRESP);
    while (issued < NUM_TXN || ap.valid || dp.valid) begin
      // Outputs sampled mid-cycle, well clear of both edges
      @(negedge HCLK);
      ready = HREADYOUT;
      rdata = HRDATA;
      resp  = HRESP;
      @(posedge HCLK);
      if (!ready) begin
        dp_waits++;
      end else begin
        if (dp.valid) begin
          complete_data_phase(rdata, resp);
        end
        // Read meeting a pending partial write to the same word
        dp_exp_waits = (ap.valid && !ap.write && dp.valid && dp.write &&
                        word_of(ap.addr) == word_of(dp.addr) &&
                        lanes_of(dp.size, int'(dp.addr[1:0])) != 4'hF) ? 1 : 0;
        dp       = ap;
        dp_waits = 0;
        dp_wdata = take_bits(32);
      end
      #1;
      if (ready) begin
        if (issued < NUM_TXN) begin
          pick_transfer();
        end else begin
          drive_idle();
        end
        HWDATA = dp_wdata;
      end
    end
    $display("Checked %0d reads, %0d wait states seen", reads, waited);
    $display("Test completed successfully");
    $finish;
  end

  initial begin
    repeat (20 * NUM_TXN) @(posedge HCLK);
    report_failure($sformatf("Watchdog expired: the run did not end within %0d cycles",
                             20 * NUM_TXN));
  end

endmodule

// File: ahb_sram.f
ahb_sram_pkg.sv
ahb_sram_addr_phase.sv
sram_1r1w.sv
ahb_sram_resp.sv
ahb_sram.sv
tb_clk_gen.sv
tb_ahb_sram.sv

// File: Makefile
# Verilator build, run and lint for the AHB-Lite SRAM slave

VERILATOR ?= verilator
TOP       ?= tb_ahb_sram
RTL_TOP   ?= ahb_sram
FILELIST  ?= ahb_sram.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Pass only if the pass line shows up in the simulation output
run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
